// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = halfAccumTb
FILELIST = halfAccum.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSLINE = Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASSLINE)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== halfAccum.f ====
+incdir+tests
source/halfFloatPkg.sv
source/fpAlign.sv
source/fpNormalize.sv
source/fpRound.sv
source/fp16AddPipe.sv
source/accumControl.sv
source/halfAccum.sv
tests/halfAccumTb.sv

// ==== source/accumControl.sv ====
`default_nettype none

module accumControl (
	input  logic                      ap_clk,
	input  logic                      ap_rst,
	input  logic                      ap_start,
	input  logic                      ap_continue,
	input  halfFloatPkg::operandSet_t operands,
	input  halfFloatPkg::half_t       addSum,
	output logic                      ap_done,
	output logic                      ap_idle,
	output logic                      ap_ready,
	output halfFloatPkg::half_t       sumOut,
	output logic                      sumValid,
	output halfFloatPkg::half_t       addA,
	output halfFloatPkg::half_t       addB
);
	import halfFloatPkg::*;

	accumState_t                   state;
	logic [$clog2(addLatency)-1:0] waitCount; // Counts down to the adder result
	opIndex_t                      index;
	operandSet_t                   opsReg;    // Captured at start
	half_t                         runSum;
	half_t                         heldSum;   // Last posted sum
	logic                          doneReg;
	logic                          accept;
	logic                          finish;
	logic                          waitLast;

	assign accept   = (state == Idle) & ap_start & ~doneReg;
	assign finish   = (state == Issue) & (index == opIndex_t'(numOperands));
	assign waitLast = (state == Wait) & (waitCount == '0);

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state     <= Idle;
			index     <= '0;
			waitCount <= '0;
		end else begin
			case (state)
				Idle: begin
					if (accept) begin
						state <= Issue;
						index <= '0;
					end
				end
				Issue: begin
					if (finish) begin
						state <= Idle;
					end else begin
						state     <= Wait; // Pair goes into the adder now
						waitCount <= ($clog2(addLatency))'(addLatency - 1);
					end
				end
				Wait: begin
					if (waitLast) begin
						state <= Issue;
						index <= index + opIndex_t'(1);
					end else begin
						waitCount <= waitCount - ($clog2(addLatency))'(1);
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Operands and running sum
	always_ff @(posedge ap_clk) begin
		if (accept) begin
			opsReg <= operands;
			runSum <= '0; // Fold starts from +0
		end else if (waitLast) begin
			runSum <= addSum;
		end
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			heldSum <= '0;
			doneReg <= 1'b0;
		end else begin
			if (finish) heldSum <= runSum;
			if (ap_continue) begin
				doneReg <= 1'b0;
			end else if (finish) begin
				doneReg <= 1'b1; // Blocks new starts until continue
			end
		end
	end

	always_comb begin
		case (index[1:0])
			2'd0: addB = opsReg.op0;
			2'd1: addB = opsReg.op1;
			2'd2: addB = opsReg.op2;
			default: addB = opsReg.op3;
		endcase
	end

	assign addA     = runSum;
	assign ap_done  = finish | doneReg;
	assign ap_ready = finish;
	assign sumValid = finish;
	assign sumOut   = finish ? runSum : heldSum; // Sum shows on the finish cycle itself
	assign ap_idle  = (state == Idle) & ~ap_start;

endmodule

`default_nettype wire

// ==== source/fp16AddPipe.sv ====
`default_nettype none

module fp16AddPipe (
	input  logic                ap_clk,
	input  logic                ap_rst,
	input  halfFloatPkg::half_t addA,
	input  halfFloatPkg::half_t addB,
	output halfFloatPkg::half_t addSum
);
	import halfFloatPkg::*;

	half_t        aReg;      // Stage 1
	half_t        bReg;
	alignedPair_t alignNext;
	alignedPair_t alignReg;  // Stage 2
	rawSum_t      rawNext;
	rawSum_t      rawReg;    // Stage 3
	normSum_t     normNext;
	normSum_t     normReg;   // Stage 4
	half_t        roundNext;
	half_t        roundReg;  // Stage 5
	half_t        outReg;    // Stage 6

	fpAlign uAlign (
		.opA     (aReg),
		.opB     (bReg),
		.aligned (alignNext)
	);

	// Larger operand is always first, so no negative result
	always_comb begin
		rawNext.sign     = alignReg.sign;
		rawNext.exponent = alignReg.exponent;
		if (alignReg.effSub) begin
			rawNext.sig = alignReg.bigSig - alignReg.smallSig;
		end else begin
			rawNext.sig = alignReg.bigSig + alignReg.smallSig;
		end
	end

	fpNormalize uNormalize (
		.raw  (rawReg),
		.norm (normNext)
	);

	fpRound uRound (
		.norm   (normReg),
		.result (roundNext)
	);

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			aReg     <= '0;
			bReg     <= '0;
			alignReg <= '0;
			rawReg   <= '0;
			normReg  <= '0;
			roundReg <= '0;
			outReg   <= '0;
		end else begin
			aReg     <= addA;
			bReg     <= addB;
			alignReg <= alignNext;
			rawReg   <= rawNext;
			normReg  <= normNext;
			roundReg <= roundNext;
			outReg   <= roundReg;
		end
	end

	assign addSum = outReg;

endmodule

`default_nettype wire

// ==== source/fpAlign.sv ====
`default_nettype none

module fpAlign (
	input  halfFloatPkg::half_t        opA,
	input  halfFloatPkg::half_t        opB,
	output halfFloatPkg::alignedPair_t aligned
);
	import halfFloatPkg::*;

	logic      swap;     // B is larger in magnitude
	half_t     bigOp;
	half_t     smallOp;
	expField_t expBig;
	expField_t expSmall;
	expField_t shiftAmt; // Exponent difference
	sigWide_t  sigBig;
	sigWide_t  sigSmall;
	sigWide_t  shifted;
	logic      lost;     // Any one shifted out

	// Magnitude compare on exponent and fraction together
	assign swap = opB[expBits+mantBits-1:0] > opA[expBits+mantBits-1:0];
	assign bigOp   = swap ? opB : opA;
	assign smallOp = swap ? opA : opB;

	assign expBig   = bigOp[expBits+mantBits-1:mantBits];
	assign expSmall = smallOp[expBits+mantBits-1:mantBits];
	assign shiftAmt = expBig - expSmall;

	// Hidden one only for nonzero exponent, so a zero operand adds nothing
	assign sigBig   = {1'b0, |expBig, bigOp[mantBits-1:0], {extraBits{1'b0}}};
	assign sigSmall = {1'b0, |expSmall, smallOp[mantBits-1:0], {extraBits{1'b0}}};

	assign shifted = sigSmall >> shiftAmt;
	assign lost    = (shifted << shiftAmt) != sigSmall; // Shift back and compare

	always_comb begin
		aligned.sign     = bigOp[expBits+mantBits];
		aligned.effSub   = opA[expBits+mantBits] ^ opB[expBits+mantBits];
		aligned.exponent = expBig;
		aligned.bigSig   = sigBig;
		// Bits lost in alignment collapse into sticky
		aligned.smallSig = {shifted[$bits(sigWide_t)-1:1], shifted[0] | lost};
	end

endmodule

`default_nettype wire

// ==== source/fpNormalize.sv ====
`default_nettype none

module fpNormalize (
	input  halfFloatPkg::rawSum_t  raw,
	output halfFloatPkg::normSum_t norm
);
	import halfFloatPkg::*;

	expField_t lzCount; // Zeros above the first one, below the carry bit
	sigWide_t  shifted;
	logic      carryOut;

	assign carryOut = raw.sig[$bits(sigWide_t)-1];

	// Priority search from the bottom, highest one wins
	always_comb begin
		lzCount = '0;
		for (int i = 0; i <= mantBits + extraBits; i++) begin
			if (raw.sig[i]) begin
				lzCount = expField_t'(mantBits + extraBits - i);
			end
		end
	end

	assign shifted = raw.sig << lzCount;

	always_comb begin
		norm.sign = raw.sign;
		norm.zero = raw.sig == '0;
		if (carryOut) begin
			// Sum reached 2.0 or more, one step right
			norm.exponent = {1'b0, raw.exponent} + (expBits + 1)'(1);
			norm.fraction = raw.sig[mantBits+extraBits:extraBits+1];
			norm.guard    = raw.sig[extraBits];
			norm.round    = raw.sig[extraBits-1];
			norm.sticky   = |raw.sig[extraBits-2:0];
		end else begin
			// Cancellation or plain case, shift left by zero count
			norm.exponent = {1'b0, raw.exponent} - {1'b0, lzCount}; // May wrap negative
			norm.fraction = shifted[mantBits+extraBits-1:extraBits];
			norm.guard    = shifted[extraBits-1];
			norm.round    = shifted[extraBits-2];
			norm.sticky   = |shifted[extraBits-3:0];
		end
	end

endmodule

`default_nettype wire

// ==== source/fpRound.sv ====
`default_nettype none

module fpRound (
	input  halfFloatPkg::normSum_t norm,
	output halfFloatPkg::half_t    result
);
	import halfFloatPkg::*;

	logic              roundUp;
	logic [mantBits:0] mantPlus;  // Room for mantissa carry
	logic [expBits:0]  expAdj;
	logic              underflow;
	logic              overflow;

	// Nearest even, ties go to a clear LSB
	assign roundUp  = norm.guard & (norm.round | norm.sticky | norm.fraction[0]);
	assign mantPlus = {1'b0, norm.fraction} + (mantBits + 1)'(roundUp);
	assign expAdj   = norm.exponent + (expBits + 1)'(mantPlus[mantBits]); // Renormalize

	// Sign of the incoming exponent decides, not the adjusted one
	assign underflow = norm.exponent[expBits] | (expAdj == '0);
	assign overflow  = ~norm.exponent[expBits] & (expAdj >= (expBits + 1)'(expInf));

	always_comb begin
		if (norm.zero) begin
			result = '0; // Exact cancellation is +0
		end else if (underflow) begin
			result = {norm.sign, {(expBits + mantBits){1'b0}}}; // Flush
		end else if (overflow) begin
			result = {norm.sign, expField_t'(expInf), mantField_t'(0)}; // Infinity
		end else begin
			result = {norm.sign, expAdj[expBits-1:0], mantPlus[mantBits-1:0]};
		end
	end

endmodule

`default_nettype wire

// ==== source/halfAccum.sv ====
`default_nettype none

module halfAccum (
	input  logic                      ap_clk,
	input  logic                      ap_rst,
	input  logic                      ap_start,
	input  logic                      ap_continue,
	input  halfFloatPkg::operandSet_t operands,
	output logic                      ap_done,
	output logic                      ap_ready,
	output logic                      ap_idle,
	output halfFloatPkg::half_t       sumOut,
	output logic                      sumValid
);
	import halfFloatPkg::*;

	half_t addA;   // Running sum
	half_t addB;   // Current operand
	half_t addSum; // Adder result, six cycles later

	accumControl uControl (
		.ap_clk      (ap_clk),
		.ap_rst      (ap_rst),
		.ap_start    (ap_start),
		.ap_continue (ap_continue),
		.operands    (operands),
		.addSum      (addSum),
		.ap_done     (ap_done),
		.ap_idle     (ap_idle),
		.ap_ready    (ap_ready),
		.sumOut      (sumOut),
		.sumValid    (sumValid),
		.addA        (addA),
		.addB        (addB)
	);

	fp16AddPipe uAdder (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.addA   (addA),
		.addB   (addB),
		.addSum (addSum)
	);

endmodule

`default_nettype wire

// ==== source/halfFloatPkg.sv ====
`default_nettype none

package halfFloatPkg;
	localparam int expBits     = 5;
	localparam int mantBits    = 10;
	localparam int expBias     = 15;
	localparam int extraBits   = 3;               // Guard, round, sticky
	localparam int numOperands = 4;               // Values summed per run
	localparam int addLatency  = 6;               // Adder depth in cycles
	localparam int expInf      = 2 * expBias + 1; // All-ones exponent code

	typedef logic [expBits+mantBits:0]          half_t;
	typedef logic [expBits-1:0]                 expField_t;
	typedef logic [mantBits-1:0]                mantField_t;
	typedef logic [mantBits+extraBits+1:0]      sigWide_t; // Carry, hidden one, fraction, GRS
	typedef logic [$clog2(numOperands+1)-1:0]   opIndex_t;

	// Operand 0 sits in the top word
	typedef struct packed {
		half_t op0;
		half_t op1;
		half_t op2;
		half_t op3;
	} operandSet_t;

	typedef struct packed {
		logic      sign;     // Sign of the larger magnitude
		logic      effSub;   // Signs differ
		expField_t exponent; // Common exponent
		sigWide_t  bigSig;
		sigWide_t  smallSig; // Shifted right, sticky in bit 0
	} alignedPair_t;

	typedef struct packed {
		logic      sign;
		expField_t exponent;
		sigWide_t  sig;      // Unnormalized
	} rawSum_t;

	typedef struct packed {
		logic             sign;
		logic [expBits:0] exponent; // Top bit set means below zero
		mantField_t       fraction;
		logic             guard;
		logic             round;
		logic             sticky;
		logic             zero;     // Exact cancellation
	} normSum_t;

	typedef enum logic [1:0] {
		Idle,
		Issue,
		Wait
	} accumState_t;
endpackage

`default_nettype wire

// ==== tests/fp16Model.svh ====
`ifndef FP16_MODEL_SVH
`define FP16_MODEL_SVH

// Exact value in units of 2^-24 that holds any finite fp16
function automatic longint toFixed(input logic [15:0] h);
	longint mag;
	if (h[14:10] == 5'd0) begin
		mag = 0; // Zero or flushed value
	end else begin
		mag = longint'({1'b1, h[9:0]}) << (h[14:10] - 5'd1);
	end
	return h[15] ? -mag : mag;
endfunction

// Back to fp16 with nearest even and flush below exponent one
function automatic logic [15:0] fromFixed(input longint v);
	logic   sign;
	longint mag;
	longint keep; // 11-bit significand after rounding
	longint rem;
	longint half;
	int     msb;
	int     sh;
	int     e;
	sign = v < 0;
	mag  = sign ? -v : v;
	if (mag == 0) begin
		return 16'h0000; // Exact cancellation is +0
	end
	msb = 0;
	for (int i = 0; i < 64; i++) begin
		if (mag[i]) msb = i;
	end
	if (msb > 10) begin
		sh   = msb - 10;
		keep = mag >> sh;
		rem  = mag & ((longint'(1) << sh) - 1); // Bits dropped
		half = longint'(1) << (sh - 1);
		if (rem > half || (rem == half && keep[0])) keep = keep + 1;
		if (keep == 2048) begin
			keep = keep >> 1; // Carry into the next binade
			msb  = msb + 1;
		end
	end else begin
		keep = mag << (10 - msb);
	end
	e = msb - 9;
	if (e < 1) return {sign, 15'h0000};
	if (e > 30) return {sign, 5'h1F, 10'h000};
	return {sign, 5'(e), keep[9:0]};
endfunction

function automatic logic [15:0] addHalf(input logic [15:0] a, input logic [15:0] b);
	return fromFixed(toFixed(a) + toFixed(b));
endfunction

// Same order as the hardware starting from +0
function automatic logic [15:0] foldSum(input operandSet_t ops);
	logic [15:0] acc;
	acc = 16'h0000;
	acc = addHalf(acc, ops.op0);
	acc = addHalf(acc, ops.op1);
	acc = addHalf(acc, ops.op2);
	acc = addHalf(acc, ops.op3);
	return acc;
endfunction

// Normal operand with biased exponent 10 to 20 and random sign
function automatic logic [15:0] makeOperand(input logic [31:0] r);
	logic [4:0] e;
	e = 5'(32'd10 + 32'(r[23:16]) % 32'd11);
	return {r[31], e, r[9:0]};
endfunction

`endif

// ==== tests/halfAccumTb.sv ====
`default_nettype none

module halfAccumTb;
	import halfFloatPkg::*;

	`include "fp16Model.svh"

	localparam int clockPeriod = 8;
	localparam int resetCycles = 16;
	localparam int randomRuns  = 200;
	localparam int totalRuns   = randomRuns + 5; // Plus four directed and one blocked
	localparam int finishCycle = numOperands * (1 + addLatency) + 1;
	localparam int runLimit    = 40; // Cycles allowed per run

	logic        ap_clk;
	logic        ap_rst;
	logic        ap_start;
	logic        ap_continue;
	operandSet_t operands;
	logic        ap_done;
	logic        ap_ready;
	logic        ap_idle;
	half_t       sumOut;
	logic        sumValid;

	logic [31:0] lcgState;
	int          mismatchCount;
	int          otherCount;
	half_t       lastSum; // Last sum the DUT posted

	halfAccum uut (
		.ap_clk      (ap_clk),
		.ap_rst      (ap_rst),
		.ap_start    (ap_start),
		.ap_continue (ap_continue),
		.operands    (operands),
		.ap_done     (ap_done),
		.ap_ready    (ap_ready),
		.ap_idle     (ap_idle),
		.sumOut      (sumOut),
		.sumValid    (sumValid)
	);

	initial ap_clk = 1'b0;
	always #(clockPeriod / 2) ap_clk = ~ap_clk;

	function logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] want);
		assert (got === want) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
			mismatchCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic want);
		assert (got === want) else begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, want);
			mismatchCount++;
		end
	endtask

	// Quiet cycles, output must hold
	task automatic holdGap(input int cycles);
		repeat (cycles) begin
			@(negedge ap_clk);
			checkBit("sumValid", sumValid, 1'b0);
			checkValue("sumOut held", sumOut, lastSum);
		end
	endtask

	// One run from start to posted sum, DUT idle with done clear on entry
	task automatic runSet(input operandSet_t ops);
		half_t want;
		int    cycles;
		want = foldSum(ops);
		@(posedge ap_clk);
		ap_start <= 1'b1;
		operands <= ops;
		@(posedge ap_clk); // Accepting edge
		ap_start <= 1'b0;
		operands <= '0;    // Must already be captured
		cycles = 0;
		do begin
			@(negedge ap_clk);
			cycles++;
		end while (!sumValid && cycles < runLimit);
		assert (sumValid) else begin
			$display("No sumValid within %0d cycles of the start, at %0t", runLimit, $time);
			otherCount++;
		end
		checkValue("finish cycle", 16'(cycles), 16'(finishCycle));
		checkBit("ap_done", ap_done, 1'b1);
		checkBit("ap_ready", ap_ready, 1'b1);
		checkValue("sumOut", sumOut, want);
		lastSum = want;
		holdGap(1); // Strobe lasts one cycle
	endtask

	// Done held without continue, starts ignored until the pulse
	task automatic blockedRun(input operandSet_t ops);
		@(posedge ap_clk);
		ap_continue <= 1'b0;
		runSet(ops);
		@(posedge ap_clk);
		ap_start <= 1'b1;
		operands <= ops;
		repeat (runLimit) begin
			@(negedge ap_clk);
			checkBit("ap_done", ap_done, 1'b1);
			checkBit("sumValid", sumValid, 1'b0);
			checkValue("sumOut held", sumOut, lastSum);
		end
		@(posedge ap_clk);
		ap_start    <= 1'b0;
		ap_continue <= 1'b1; // Single-cycle pulse
		@(posedge ap_clk);
		ap_continue <= 1'b0;
		@(negedge ap_clk);
		checkBit("ap_done", ap_done, 1'b0);
		checkBit("ap_idle", ap_idle, 1'b1);
		@(posedge ap_clk);
		ap_continue <= 1'b1; // Back to free running
	endtask

	initial begin
		operandSet_t ops;
		lcgState      = 32'd38;
		mismatchCount = 0;
		otherCount    = 0;
		lastSum       = '0;
		ap_rst        = 1'b1;
		ap_start      = 1'b0;
		ap_continue   = 1'b1;
		operands      = '0;
		repeat (resetCycles) @(posedge ap_clk);
		ap_rst <= 1'b0;
		@(negedge ap_clk);
		checkBit("ap_idle", ap_idle, 1'b1); // Reset state
		checkBit("ap_done", ap_done, 1'b0);
		checkBit("ap_ready", ap_ready, 1'b0);
		checkBit("sumValid", sumValid, 1'b0);
		checkValue("sumOut", sumOut, 16'h0000);

		for (int n = 0; n < randomRuns; n++) begin
			ops.op0 = makeOperand(nextRandom());
			ops.op1 = makeOperand(nextRandom());
			ops.op2 = makeOperand(nextRandom());
			ops.op3 = makeOperand(nextRandom());
			runSet(ops);
			holdGap(int'(nextRandom() % 32'd4));
		end

		ops = '{16'h4A3C, 16'hCA3C, 16'h3555, 16'hB555}; // x, -x, y, -y
		runSet(ops);
		checkValue("cancellation sum", sumOut, 16'h0000);
		ops = '{16'h3C00, 16'h1000, 16'h1000, 16'h1000}; // Ties stay on even 1.0
		runSet(ops);
		checkValue("tie to even", sumOut, 16'h3C00);
		ops = '{16'h3C01, 16'h1000, 16'hBC02, 16'h3C00}; // Odd LSB tie rounds up
		runSet(ops);
		checkValue("tie round up", sumOut, 16'h3C00);
		ops = '{16'h4000, 16'h1400, 16'h1400, 16'h1800};
		runSet(ops);
		checkValue("tie at 2.0", sumOut, 16'h4001);

		ops.op0 = makeOperand(nextRandom());
		ops.op1 = makeOperand(nextRandom());
		ops.op2 = makeOperand(nextRandom());
		ops.op3 = makeOperand(nextRandom());
		blockedRun(ops);
		holdGap(2);

		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount + otherCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog sized from the run count
	initial begin
		#(clockPeriod * (totalRuns * runLimit + resetCycles));
		$display("Timeout: the tests did not complete in time");
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount + 1);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
